// File: common/beat_if.sv
// one selected beat from arbiter to output stage; valid holds with stable data until ready
`timescale 1ns/1ps

interface beat_if;
   import sched_pkg::*;

   logic      valid;
   logic      ready;
   beat_t     data;
   logic      line_end;
   pipe_idx_t pipe;

   modport src (
      output valid,
      output data,
      output line_end,
      output pipe,
      input  ready
   );

   modport dst (
      input  valid,
      input  data,
      input  line_end,
      input  pipe,
      output ready
   );

endinterface

// File: common/sched_pkg.sv
// shared widths and types for the line scheduler; the tag sits in the top tag_w bits of a beat
package sched_pkg;

   localparam int num_pipes  = 8;
   localparam int beat_w     = 140;
   localparam int tag_w      = 4;
   localparam int pipe_idx_w = 3;

   typedef logic [beat_w-1:0]     beat_t;
   typedef logic [tag_w-1:0]      tag_t;
   typedef logic [pipe_idx_w-1:0] pipe_idx_t;
   typedef logic [num_pipes-1:0]  pipe_vec_t;

   // encoding 1 was concatenation in the older design, treated as off here
   typedef enum logic [1:0] {
      aggre_off           = 2'd0,
      aggre_concat_unused = 2'd1,
      aggre_line          = 2'd2,
      aggre_tag           = 2'd3
   } aggre_mode_e;

   // debug view of the scheduler
   // pipe N is encoded as N+1
   typedef enum logic [3:0] {
      sch_idle  = 4'd0,
      sch_pipe0 = 4'd1,
      sch_pipe1 = 4'd2,
      sch_pipe2 = 4'd3,
      sch_pipe3 = 4'd4,
      sch_pipe4 = 4'd5,
      sch_pipe5 = 4'd6,
      sch_pipe6 = 4'd7,
      sch_pipe7 = 4'd8
   } sch_state_e;

endpackage

// File: design/aggre_sched_top.sv
// line scheduler top; any aggr_id works, pipes hold each beat until in_ready, one cycle to output
`timescale 1ns/1ps

module aggre_sched_top #(
   parameter sched_pkg::tag_t aggr_id = '0
) (
   input  logic                   aggre_clk,
   input  logic                   aggre_clk_rst_n,
   input  sched_pkg::aggre_mode_e aggre_mode,
   input  sched_pkg::pipe_vec_t   pipe_en,
   input  sched_pkg::pipe_vec_t   in_valid,
   input  sched_pkg::beat_t       in_data [sched_pkg::num_pipes],
   input  sched_pkg::pipe_vec_t   in_line_end,
   output sched_pkg::pipe_vec_t   in_ready,
   output logic                   out_valid,
   input  logic                   out_ready,
   output sched_pkg::beat_t       out_data,
   output logic                   out_line_end,
   output sched_pkg::pipe_idx_t   out_pipe,
   output sched_pkg::sch_state_e  sch_state
);
   import sched_pkg::*;

   pipe_vec_t req;
   pipe_vec_t drop;

   beat_if sel_if ();

   request_filter i_request_filter (
      .aggre_mode (aggre_mode),
      .pipe_en    (pipe_en),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .aggr_id    (aggr_id),
      .req        (req),
      .drop       (drop)
   );

   line_arbiter i_line_arbiter (
      .aggre_clk       (aggre_clk),
      .aggre_clk_rst_n (aggre_clk_rst_n),
      .req             (req),
      .drop            (drop),
      .in_valid        (in_valid),
      .in_data         (in_data),
      .in_line_end     (in_line_end),
      .in_ready        (in_ready),
      .sch_state       (sch_state),
      .sel             (sel_if.src)
   );

   output_stage i_output_stage (
      .aggre_clk       (aggre_clk),
      .aggre_clk_rst_n (aggre_clk_rst_n),
      .out_ready       (out_ready),
      .sel             (sel_if.dst),
      .out_valid       (out_valid),
      .out_data        (out_data),
      .out_line_end    (out_line_end),
      .out_pipe        (out_pipe)
   );

endmodule

// File: design/output_stage.sv
// single-entry output register; full rate when out_ready stays high, holds its beat otherwise
`timescale 1ns/1ps

module output_stage (
   input  logic                 aggre_clk,
   input  logic                 aggre_clk_rst_n,
   input  logic                 out_ready,
   beat_if.dst                  sel,
   output logic                 out_valid,
   output sched_pkg::beat_t     out_data,
   output logic                 out_line_end,
   output sched_pkg::pipe_idx_t out_pipe
);

   logic load;

   // take a new beat when empty or when the current one leaves this cycle
   assign sel.ready = ~out_valid | out_ready;
   assign load      = sel.valid & sel.ready;

   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         out_valid <= 1'b0;
      end else if (sel.ready) begin
         out_valid <= sel.valid;
      end
   end

   always_ff @(posedge aggre_clk) begin
      if (load) begin
         out_data     <= sel.data;
         out_line_end <= sel.line_end;
         out_pipe     <= sel.pipe;
      end
   end

endmodule

// File: design/sched/line_arbiter.sv
// line-atomic round robin; one idle cycle between lines, mode and enables change only when idle
`timescale 1ns/1ps

module line_arbiter (
   input  logic                   aggre_clk,
   input  logic                   aggre_clk_rst_n,
   input  sched_pkg::pipe_vec_t   req,
   input  sched_pkg::pipe_vec_t   drop,
   input  sched_pkg::pipe_vec_t   in_valid,
   input  sched_pkg::beat_t       in_data [sched_pkg::num_pipes],
   input  sched_pkg::pipe_vec_t   in_line_end,
   output sched_pkg::pipe_vec_t   in_ready,
   output sched_pkg::sch_state_e  sch_state,
   beat_if.src                    sel
);
   import sched_pkg::*;

   pipe_idx_t last_idx;
   pipe_idx_t pick_idx;
   pipe_idx_t gnt_idx;
   logic      busy;

   // first requester above last_idx, wrapping
   function automatic pipe_idx_t rr_pick(input pipe_vec_t r, input pipe_idx_t last);
      pipe_idx_t cand;
      pipe_idx_t pick;
      pick = last;
      // walk from farthest to nearest so the nearest hit wins
      for (int k = num_pipes; k >= 1; k--) begin
         cand = pipe_idx_t'(last + k);
         if (r[cand]) begin
            pick = cand;
         end
      end
      return pick;
   endfunction

   assign pick_idx = rr_pick(req, last_idx);
   assign busy     = (sch_state != sch_idle);
   assign gnt_idx  = pipe_idx_t'(sch_state - 4'd1);

   always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
      if (!aggre_clk_rst_n) begin
         sch_state <= sch_idle;
         // pipe 0 gets searched first after reset
         last_idx  <= pipe_idx_t'(num_pipes - 1);
      end else if (!busy) begin
         if (|req) begin
            sch_state <= sch_state_e'({1'b0, pick_idx} + 4'd1);
            last_idx  <= pick_idx;
         end
      end else if (sel.valid && sel.ready && sel.line_end) begin
         sch_state <= sch_idle;
      end
   end

   // granted pipe steered straight onto the beat bus
   assign sel.valid    = busy & in_valid[gnt_idx] & ~drop[gnt_idx];
   assign sel.data     = in_data[gnt_idx];
   assign sel.line_end = in_line_end[gnt_idx];
   assign sel.pipe     = gnt_idx;

   // dropped beats are acked whether granted or not
   always_comb begin
      for (int i = 0; i < num_pipes; i++) begin
         in_ready[i] = drop[i] | (busy & (gnt_idx == pipe_idx_t'(i)) & sel.ready);
      end
   end

endmodule

// File: design/sched/request_filter.sv
// combinational request decode; pipe_en only applies in line mode, tag compare only in tag mode
`timescale 1ns/1ps

module request_filter (
   input  sched_pkg::aggre_mode_e aggre_mode,
   input  sched_pkg::pipe_vec_t   pipe_en,
   input  sched_pkg::pipe_vec_t   in_valid,
   input  sched_pkg::beat_t       in_data [sched_pkg::num_pipes],
   input  sched_pkg::tag_t        aggr_id,
   output sched_pkg::pipe_vec_t   req,
   output sched_pkg::pipe_vec_t   drop
);
   import sched_pkg::*;

   pipe_vec_t tag_hit;

   // tag lives in the top bits of each beat
   always_comb begin
      for (int i = 0; i < num_pipes; i++) begin
         tag_hit[i] = (in_data[i][beat_w-1 -: tag_w] == aggr_id);
      end
   end

   always_comb begin
      req  = '0;
      drop = '0;
      case (aggre_mode)
         aggre_line: begin
            req = in_valid & pipe_en;
         end
         aggre_tag: begin
            req  = in_valid & tag_hit;
            // foreign beats are swallowed
            drop = in_valid & ~tag_hit;
         end
         default: begin
            // off, and the old concat encoding
            req  = '0;
            drop = '0;
         end
      endcase
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the line scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module tb_aggre_sched --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Regression passed" sim.log; then
   echo "simulation PASS"
else
   echo "simulation FAIL"
   exit 1
fi

// File: sim/tb_stim_table.svh
// stimulus rows for tb_aggre_sched; lines of a row must drain fully, tags assume aggr_id 5
`ifndef TB_STIM_TABLE_SVH
`define TB_STIM_TABLE_SVH

// row columns: mode, pipe_en, round-robin order check on the first eight lines
typedef struct packed {
   aggre_mode_e mode;
   pipe_vec_t   pipe_en;
   logic        rr_check;
} row_t;

// line columns: row, pipe, tag, length in beats, reaches the output
typedef struct packed {
   int        row;
   pipe_idx_t pipe;
   tag_t      tag;
   int        len;
   logic      fwd;
} line_t;

localparam int num_rows  = 6;
localparam int num_lines = 28;

localparam row_t rows [num_rows] = '{
   '{aggre_line,          8'hff, 1'b1},
   '{aggre_line,          8'hff, 1'b0},
   '{aggre_line,          8'h5a, 1'b0},
   '{aggre_tag,           8'hff, 1'b0},
   '{aggre_off,           8'hff, 1'b0},
   '{aggre_concat_unused, 8'hff, 1'b0}
};

localparam line_t lines [num_lines] = '{
   '{0, 3'd0, 4'h0, 2, 1'b1},
   '{0, 3'd1, 4'h0, 3, 1'b1},
   '{0, 3'd2, 4'h0, 1, 1'b1},
   '{0, 3'd3, 4'h0, 4, 1'b1},
   '{0, 3'd4, 4'h0, 2, 1'b1},
   '{0, 3'd5, 4'h0, 3, 1'b1},
   '{0, 3'd6, 4'h0, 1, 1'b1},
   '{0, 3'd7, 4'h0, 2, 1'b1},
   '{1, 3'd0, 4'h1, 3, 1'b1},
   '{1, 3'd2, 4'h2, 4, 1'b1},
   '{1, 3'd0, 4'h3, 2, 1'b1},
   '{1, 3'd3, 4'h4, 5, 1'b1},
   '{1, 3'd5, 4'h5, 2, 1'b1},
   '{1, 3'd7, 4'h6, 3, 1'b1},
   '{2, 3'd0, 4'h0, 2, 1'b0},
   '{2, 3'd1, 4'h0, 3, 1'b1},
   '{2, 3'd2, 4'h0, 2, 1'b0},
   '{2, 3'd3, 4'h0, 2, 1'b1},
   '{2, 3'd6, 4'h0, 1, 1'b1},
   '{3, 3'd0, 4'h5, 3, 1'b1},
   '{3, 3'd1, 4'h3, 2, 1'b0},
   '{3, 3'd2, 4'h5, 2, 1'b1},
   '{3, 3'd0, 4'h9, 2, 1'b0},
   '{3, 3'd4, 4'h5, 4, 1'b1},
   '{3, 3'd7, 4'h0, 1, 1'b0},
   '{4, 3'd0, 4'h5, 2, 1'b0},
   '{4, 3'd3, 4'h5, 1, 1'b0},
   '{5, 3'd5, 4'h5, 2, 1'b0}
};

`endif

// File: sim/tb_aggre_sched.sv
// testbench for aggre_sched_top built with aggr_id 5; each table row drains before the next starts
`timescale 1ns/1ps

module tb_aggre_sched;
   import sched_pkg::*;

   localparam tag_t agg_id      = 4'h5;
   localparam int   hold_cycles = 12;

   // debug state expected while each pipe is served
   localparam sch_state_e pipe_state [num_pipes] = '{
      sch_pipe0, sch_pipe1, sch_pipe2, sch_pipe3,
      sch_pipe4, sch_pipe5, sch_pipe6, sch_pipe7
   };

   `include "tb_stim_table.svh"

   logic        aggre_clk;
   logic        aggre_clk_rst_n;
   aggre_mode_e aggre_mode;
   pipe_vec_t   pipe_en;
   pipe_vec_t   in_valid;
   beat_t       in_data [num_pipes];
   pipe_vec_t   in_line_end;
   pipe_vec_t   in_ready;
   logic        out_valid;
   logic        out_ready;
   beat_t       out_data;
   logic        out_line_end;
   pipe_idx_t   out_pipe;
   sch_state_e  sch_state;

   int          cur_row;
   pipe_vec_t   drv_busy;
   beat_t       exp_q [num_pipes][$];
   logic        end_q [num_pipes][$];
   pipe_idx_t   line_log [$];

   aggre_sched_top #(.aggr_id(agg_id)) i_dut (.*);

   initial begin
      aggre_clk = 1'b0;
      forever #5 aggre_clk = ~aggre_clk;
   end

   task automatic abort_run();
      $display("Regression failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_beat(string name, beat_t exp, beat_t act);
      if (act !== exp) begin
         $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_pipe(string name, pipe_idx_t exp, pipe_idx_t act);
      if (act !== exp) begin
         $display("ERR %0t %s exp=%0d act=%0d", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_state(string name, sch_state_e exp, sch_state_e act);
      if (act !== exp) begin
         $display("ERR %0t %s exp=%s act=%s", $time, name, exp.name(), act.name());
         abort_run();
      end
   endtask

   task automatic check_vec(string name, pipe_vec_t exp, pipe_vec_t act);
      if (act !== exp) begin
         $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_flag(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_idle();
      check_flag("out_valid", 1'b0, out_valid);
      check_vec("in_ready", '0, in_ready);
      check_state("sch_state", sch_idle, sch_state);
   endtask

   // tag on top, pipe, line and beat number below, copies spread through the middle
   function automatic beat_t make_beat(tag_t tag, int pipe, int line_id, int beat_no);
      beat_t b;
      b = '0;
      b[47:40]  = 8'(pipe);
      b[39:20]  = 20'(line_id);
      b[19:0]   = 20'(beat_no);
      b[95:48]  = ~b[47:0];
      b[135:96] = b[39:0];
      b[beat_w-1 -: tag_w] = tag;
      return b;
   endfunction

   // whether a pipe's beats get taken at all in the current mode
   function automatic logic pipe_accepts(int p);
      case (aggre_mode)
         aggre_line: return pipe_en[p];
         aggre_tag:  return 1'b1;
         default:    return 1'b0;
      endcase
   endfunction

   function automatic int pending();
      int cnt;
      cnt = 0;
      for (int p = 0; p < num_pipes; p++) begin
         cnt += exp_q[p].size();
      end
      return cnt;
   endfunction

   task automatic load_expected(int r);
      for (int n = 0; n < num_lines; n++) begin
         if (lines[n].row == r && lines[n].fwd) begin
            for (int b = 0; b < lines[n].len; b++) begin
               exp_q[lines[n].pipe].push_back(make_beat(lines[n].tag, int'(lines[n].pipe), n, b));
               end_q[lines[n].pipe].push_back(b == lines[n].len - 1);
            end
         end
      end
   endtask

   task automatic check_rr(int base);
      if (line_log.size() < base + num_pipes) begin
         $display("fewer than eight lines came out in the round-robin row");
         abort_run();
      end
      for (int i = 0; i < num_pipes; i++) begin
         check_pipe("out_pipe", pipe_idx_t'(i), line_log[base + i]);
      end
   endtask

   // one driver per pipe, sends that pipe's lines of the current row in table order
   for (genvar g = 0; g < num_pipes; g++) begin : g_drv
      logic  v;
      beat_t d;
      logic  e;
      int    done_row;

      assign in_valid[g]    = v;
      assign in_data[g]     = d;
      assign in_line_end[g] = e;
      assign drv_busy[g]    = (done_row != cur_row);

      initial begin : pipe_driver
         int   gap;
         logic first;
         v        = 1'b0;
         d        = '0;
         e        = 1'b0;
         done_row = -1;
         forever begin
            @(negedge aggre_clk);
            if (done_row != cur_row) begin
               // round-robin row starts every pipe on the same edge
               first = rows[cur_row].rr_check;
               for (int n = 0; n < num_lines; n++) begin
                  if (lines[n].row == cur_row && int'(lines[n].pipe) == g) begin
                     if (pipe_accepts(g)) begin
                        for (int b = 0; b < lines[n].len; b++) begin
                           gap   = first ? 0 : int'($urandom_range(2, 0));
                           first = 1'b0;
                           if (gap > 0) begin
                              v = 1'b0;
                              repeat (gap) @(negedge aggre_clk);
                           end
                           v = 1'b1;
                           d = make_beat(lines[n].tag, g, n, b);
                           e = (b == lines[n].len - 1);
                           do @(posedge aggre_clk); while (in_ready[g] !== 1'b1);
                           @(negedge aggre_clk);
                        end
                        v = 1'b0;
                     end else begin
                        // beat offered but never taken
                        v = 1'b1;
                        d = make_beat(lines[n].tag, g, n, 0);
                        e = (lines[n].len == 1);
                        repeat (hold_cycles) @(posedge aggre_clk);
                        @(negedge aggre_clk);
                        v = 1'b0;
                     end
                  end
               end
               done_row = cur_row;
            end
         end
      end
   end

   // random back-pressure
   initial begin
      out_ready = 1'b0;
      wait (aggre_clk_rst_n === 1'b1);
      forever begin
         @(negedge aggre_clk);
         out_ready = ($urandom_range(3, 0) != 0);
      end
   end

   initial begin : scoreboard
      beat_t     exp_b;
      logic      exp_e;
      logic      in_line;
      pipe_idx_t line_pipe;
      in_line   = 1'b0;
      line_pipe = '0;
      forever begin
         @(posedge aggre_clk);
         if (aggre_clk_rst_n) begin
            if (aggre_mode == aggre_line) begin
               // masked pipes never get a ready
               check_vec("in_ready", '0, in_ready & ~pipe_en);
            end else if (aggre_mode != aggre_tag) begin
               check_idle();
            end
            // a forwarded beat is taken only from the granted pipe
            for (int p = 0; p < num_pipes; p++) begin
               if (in_valid[p] && in_ready[p] && lines[int'(in_data[p][39:20])].fwd) begin
                  check_state("sch_state", pipe_state[p], sch_state);
               end
            end
            if (out_valid && out_ready) begin
               if (in_line) begin
                  check_pipe("out_pipe", line_pipe, out_pipe);
               end else begin
                  line_log.push_back(out_pipe);
                  line_pipe = out_pipe;
               end
               if (exp_q[out_pipe].size() == 0) begin
                  $display("output beat from pipe %0d while none was expected", out_pipe);
                  abort_run();
               end
               exp_b = exp_q[out_pipe].pop_front();
               exp_e = end_q[out_pipe].pop_front();
               check_beat("out_data", exp_b, out_data);
               check_flag("out_line_end", exp_e, out_line_end);
               in_line = ~out_line_end;
            end
         end
      end
   end

   initial begin : watchdog
      int limit;
      limit = 8;
      for (int n = 0; n < num_lines; n++) begin
         limit += lines[n].len * 40;
      end
      repeat (limit) @(posedge aggre_clk);
      $display("watchdog expired before the traffic drained");
      abort_run();
   end

   initial begin : main_seq
      int base;
      void'($urandom(32'h0b34f200));
      aggre_clk_rst_n = 1'b0;
      aggre_mode      = aggre_off;
      pipe_en         = '0;
      cur_row         = -1;
      repeat (8) @(posedge aggre_clk);
      @(negedge aggre_clk);
      aggre_clk_rst_n = 1'b1;
      @(posedge aggre_clk);
      check_idle();
      for (int r = 0; r < num_rows; r++) begin
         @(negedge aggre_clk);
         aggre_mode = rows[r].mode;
         pipe_en    = rows[r].pipe_en;
         load_expected(r);
         base = line_log.size();
         @(posedge aggre_clk);
         cur_row = r;
         do @(posedge aggre_clk); while (drv_busy != '0 || pending() != 0);
         @(posedge aggre_clk);
         check_idle();
         if (rows[r].rr_check) begin
            check_rr(base);
         end
      end
      $display("Regression passed");
      $finish;
   end

endmodule

// File: src.f
+incdir+sim
common/sched_pkg.sv
common/beat_if.sv
design/sched/request_filter.sv
design/sched/line_arbiter.sv
design/output_stage.sv
design/aggre_sched_top.sv
sim/tb_aggre_sched.sv
